//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_muldiv
FILELIST  ?= muldiv_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- div_iter.sv
module div_iter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  muldiv_pkg::exec_req_t req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output muldiv_pkg::wb_t       resp,
    input  logic                  resp_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_e;

    state_e                             state;
    logic [muldiv_pkg::div_cnt_w-1:0]   count;
    logic [muldiv_pkg::xlen-1:0]        rem_q;
    logic [muldiv_pkg::xlen-1:0]        quo_q;
    logic [muldiv_pkg::xlen-1:0]        dsr_q;
    logic [muldiv_pkg::reg_w-1:0]       dest_q;
    logic                               neg_q;
    logic                               neg_r;
    logic                               want_rem;
    logic                               div_zero;
    logic                               is_signed;
    logic                               sign_a;
    logic                               sign_b;
    logic [muldiv_pkg::xlen-1:0]        abs_a;
    logic [muldiv_pkg::xlen-1:0]        abs_b;
    logic [muldiv_pkg::xlen:0]          shifted;
    logic [muldiv_pkg::xlen:0]          diff;
    logic [muldiv_pkg::xlen-1:0]        quo_fix;
    logic [muldiv_pkg::xlen-1:0]        rem_fix;

    assign is_signed = (req.op == muldiv_pkg::op_div) || (req.op == muldiv_pkg::op_rem);
    assign sign_a    = is_signed & req.src1[muldiv_pkg::xlen-1];
    assign sign_b    = is_signed & req.src2[muldiv_pkg::xlen-1];
    assign abs_a     = sign_a ? -req.src1 : req.src1;
    assign abs_b     = sign_b ? -req.src2 : req.src2;

    // one restoring step.
    assign shifted = {rem_q, quo_q[muldiv_pkg::xlen-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    // x/0 leaves rem at |x|, so only the quotient is forced.
    // min/-1 comes out as min, rem 0, without a special case.
    assign quo_fix = div_zero ? '1 : (neg_q ? -quo_q : quo_q);
    assign rem_fix = neg_r ? -rem_q : rem_q;

    assign req_ready  = (state == st_idle);
    assign resp_valid = (state == st_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_run;
                        count <= '0;
                    end
                end
                st_run: begin
                    count <= count + 1'b1;
                    if (int'(count) == muldiv_pkg::div_cycles - 1) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (req_valid) begin
                    rem_q    <= '0;
                    quo_q    <= abs_a;
                    dsr_q    <= abs_b;
                    dest_q   <= req.dest;
                    neg_q    <= sign_a ^ sign_b;
                    neg_r    <= sign_a;
                    want_rem <= (req.op == muldiv_pkg::op_rem) || (req.op == muldiv_pkg::op_remu);
                    div_zero <= (req.src2 == '0);
                end
            end
            st_run: begin
                if (!diff[muldiv_pkg::xlen]) begin
                    rem_q <= diff[muldiv_pkg::xlen-1:0];
                    quo_q <= {quo_q[muldiv_pkg::xlen-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[muldiv_pkg::xlen-1:0];
                    quo_q <= {quo_q[muldiv_pkg::xlen-2:0], 1'b0};
                end
            end
            default: ;
        endcase
    end

    // signs and select applied to the held registers.
    always_comb begin
        resp.we   = 1'b1;
        resp.dest = dest_q;
        resp.data = want_rem ? rem_fix : quo_fix;
    end

endmodule

//--- issue_ctrl.sv
module issue_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         issue_valid,
    input  muldiv_pkg::issue_t           issue,
    output logic                         issue_ready,
    output logic [muldiv_pkg::reg_w-1:0] rf_raddr1,
    output logic [muldiv_pkg::reg_w-1:0] rf_raddr2,
    input  logic [muldiv_pkg::xlen-1:0]  rf_rdata1,
    input  logic [muldiv_pkg::xlen-1:0]  rf_rdata2,
    output logic                         mul_req_valid,
    output logic                         div_req_valid,
    output muldiv_pkg::exec_req_t        req,
    input  logic                         mul_req_ready,
    input  logic                         div_req_ready,
    input  muldiv_pkg::wb_t              wr
);

    logic [muldiv_pkg::nreg-1:0] busy;
    logic                        is_div;
    logic                        hazard_free;
    logic                        unit_ready;
    logic                        accept;

    assign is_div = muldiv_pkg::op_is_div(issue.op);

    // raw on rj/rk, waw on dest.
    assign hazard_free = !busy[issue.rj] && !busy[issue.rk] && !busy[issue.dest];
    assign unit_ready  = is_div ? div_req_ready : mul_req_ready;
    assign issue_ready = hazard_free && unit_ready;
    assign accept      = issue_valid && issue_ready;

    // unit valids stay independent of unit ready.
    assign mul_req_valid = issue_valid && hazard_free && !is_div;
    assign div_req_valid = issue_valid && hazard_free && is_div;

    assign rf_raddr1 = issue.rj;
    assign rf_raddr2 = issue.rk;

    always_comb begin
        req.op   = issue.op;
        req.dest = issue.dest;
        req.src1 = rf_rdata1;
        req.src2 = rf_rdata2;
    end

    // r0 never gets marked, so it never stalls.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wr.we) begin
                busy[wr.dest] <= 1'b0;
            end
            if (accept && issue.dest != '0) begin
                busy[issue.dest] <= 1'b1;
            end
        end
    end

endmodule

//--- mul_pipe.sv
module mul_pipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  muldiv_pkg::exec_req_t req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output muldiv_pkg::wb_t       resp,
    input  logic                  resp_ready
);

    logic                            s1_valid;
    logic                            s1_hi;
    logic [muldiv_pkg::reg_w-1:0]    s1_dest;
    logic [2*muldiv_pkg::xlen-1:0]   s1_a;
    logic [2*muldiv_pkg::xlen-1:0]   s1_b;
    logic [2*muldiv_pkg::xlen-1:0]   prod;
    logic                            s2_valid;
    logic                            s2_hi;
    logic [muldiv_pkg::reg_w-1:0]    s2_dest;
    logic [2*muldiv_pkg::xlen-1:0]   s2_prod;
    logic                            s1_ready;
    logic                            s2_ready;
    logic                            sgn;

    assign s2_ready  = !s2_valid || resp_ready;
    assign s1_ready  = !s1_valid || s2_ready;
    assign req_ready = s1_ready;

    // only mulh sign-extends; low half is the same either way.
    assign sgn = (req.op == muldiv_pkg::op_mulh);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= req_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_ready && req_valid) begin
            s1_hi   <= (req.op != muldiv_pkg::op_mul);
            s1_dest <= req.dest;
            s1_a    <= {{muldiv_pkg::xlen{sgn & req.src1[muldiv_pkg::xlen-1]}}, req.src1};
            s1_b    <= {{muldiv_pkg::xlen{sgn & req.src2[muldiv_pkg::xlen-1]}}, req.src2};
        end
        if (s2_ready && s1_valid) begin
            s2_hi   <= s1_hi;
            s2_dest <= s1_dest;
            s2_prod <= prod;
        end
    end

    // 64-bit product of the extended operands.
    assign prod = s1_a * s1_b;

    assign resp_valid = s2_valid;

    always_comb begin
        resp.we   = 1'b1;
        resp.dest = s2_dest;
        if (s2_hi) begin
            resp.data = s2_prod[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
        end else begin
            resp.data = s2_prod[muldiv_pkg::xlen-1:0];
        end
    end

endmodule

//--- muldiv_pkg.sv
package muldiv_pkg;

    localparam int xlen       = 32;
    localparam int nreg       = 32;
    localparam int reg_w      = 5;
    localparam int div_cycles = 32;
    localparam int div_cnt_w  = $clog2(div_cycles);

    // multiplier ops first, then the divider ops.
    typedef enum logic [2:0] {
        op_mul   = 3'd0,
        op_mulh  = 3'd1,
        op_mulhu = 3'd2,
        op_div   = 3'd3,
        op_divu  = 3'd4,
        op_rem   = 3'd5,
        op_remu  = 3'd6
    } op_e;

    typedef struct packed {
        op_e              op;
        logic [reg_w-1:0] dest;
        logic [reg_w-1:0] rj;
        logic [reg_w-1:0] rk;
    } issue_t;

    typedef struct packed {
        op_e              op;
        logic [reg_w-1:0] dest;
        logic [xlen-1:0]  src1;
        logic [xlen-1:0]  src2;
    } exec_req_t;

    // unit result, register write and trace.
    typedef struct packed {
        logic             we;
        logic [reg_w-1:0] dest;
        logic [xlen-1:0]  data;
    } wb_t;

    function automatic logic op_is_div(op_e op);
        return op inside {op_div, op_divu, op_rem, op_remu};
    endfunction

endpackage

//--- muldiv_top.f
muldiv_pkg.sv
regfile.sv
issue_ctrl.sv
mul_pipe.sv
div_iter.sv
wb_arbiter.sv
muldiv_top.sv
tb_muldiv.sv

//--- muldiv_top.sv
module muldiv_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_valid,
    input  muldiv_pkg::issue_t issue,
    output logic               issue_ready,
    output muldiv_pkg::wb_t    trace
);

    logic [muldiv_pkg::reg_w-1:0] rf_raddr1;
    logic [muldiv_pkg::reg_w-1:0] rf_raddr2;
    logic [muldiv_pkg::xlen-1:0]  rf_rdata1;
    logic [muldiv_pkg::xlen-1:0]  rf_rdata2;
    logic                         mul_req_valid;
    logic                         div_req_valid;
    logic                         mul_req_ready;
    logic                         div_req_ready;
    muldiv_pkg::exec_req_t        req;
    logic                         mul_resp_valid;
    logic                         mul_resp_ready;
    muldiv_pkg::wb_t              mul_resp;
    logic                         div_resp_valid;
    logic                         div_resp_ready;
    muldiv_pkg::wb_t              div_resp;
    muldiv_pkg::wb_t              wr;

    issue_ctrl i_issue_ctrl (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .rf_raddr1     (rf_raddr1),
        .rf_raddr2     (rf_raddr2),
        .rf_rdata1     (rf_rdata1),
        .rf_rdata2     (rf_rdata2),
        .mul_req_valid (mul_req_valid),
        .div_req_valid (div_req_valid),
        .req           (req),
        .mul_req_ready (mul_req_ready),
        .div_req_ready (div_req_ready),
        .wr            (wr)
    );

    regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wr)
    );

    mul_pipe i_mul_pipe (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (mul_req_valid),
        .req        (req),
        .req_ready  (mul_req_ready),
        .resp_valid (mul_resp_valid),
        .resp       (mul_resp),
        .resp_ready (mul_resp_ready)
    );

    div_iter i_div_iter (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (div_req_valid),
        .req        (req),
        .req_ready  (div_req_ready),
        .resp_valid (div_resp_valid),
        .resp       (div_resp),
        .resp_ready (div_resp_ready)
    );

    wb_arbiter i_wb_arbiter (
        .clk       (clk),
        .reset     (reset),
        .mul_valid (mul_resp_valid),
        .mul_resp  (mul_resp),
        .mul_ready (mul_resp_ready),
        .div_valid (div_resp_valid),
        .div_resp  (div_resp),
        .div_ready (div_resp_ready),
        .wr        (wr),
        .trace     (trace)
    );

endmodule

//--- regfile.sv
module regfile (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [muldiv_pkg::reg_w-1:0] raddr1,
    input  logic [muldiv_pkg::reg_w-1:0] raddr2,
    output logic [muldiv_pkg::xlen-1:0]  rdata1,
    output logic [muldiv_pkg::xlen-1:0]  rdata2,
    input  muldiv_pkg::wb_t              wr
);

    logic [muldiv_pkg::xlen-1:0] regs [muldiv_pkg::nreg];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < muldiv_pkg::nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.dest != '0) begin
            regs[wr.dest] <= wr.data;
        end
    end

    // r0 is hard-wired to zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- tb_muldiv.sv
module tb_muldiv;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 8;
    localparam int n_seed     = 7;
    localparam int n_directed = 8;
    localparam int n_mul      = 60;
    localparam int n_div      = 30;
    localparam int n_chain    = 40;
    localparam int n_mix      = 60;
    localparam int n_ops      = 2 * n_seed + n_directed + n_mul + n_div + n_chain + n_mix + 2;
    localparam int grp_mul    = 0;
    localparam int grp_div    = 1;
    localparam int grp_any    = 2;

    logic               clk;
    logic               reset;
    logic               issue_valid;
    muldiv_pkg::issue_t issue;
    logic               issue_ready;
    muldiv_pkg::wb_t    trace;

    logic [31:0] lfsr;
    logic [31:0] model_regs [32];
    logic [31:0] expected [32];
    logic [31:0] pending;
    int          errors;
    int          n_checks;
    int          n_issues;
    int          n_traces;

    muldiv_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .trace       (trace)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] expected_result(input muldiv_pkg::op_e op,
                                                    input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sres;
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        logic               by_zero;
        logic               overflow;
        logic [31:0]        result;
        sa       = a;
        sb       = b;
        sres     = '0;
        sprod    = 64'(sa) * 64'(sb);
        uprod    = 64'(a) * 64'(b);
        by_zero  = (b == 32'd0);
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (!by_zero && !overflow) begin
            sres = (op == muldiv_pkg::op_div) ? sa / sb : sa % sb;
        end
        case (op)
            muldiv_pkg::op_mul:   result = uprod[31:0];
            muldiv_pkg::op_mulh:  result = sprod[63:32];
            muldiv_pkg::op_mulhu: result = uprod[63:32];
            muldiv_pkg::op_div:   result = by_zero ? '1 : (overflow ? a : sres);
            muldiv_pkg::op_divu:  result = by_zero ? '1 : a / b;
            muldiv_pkg::op_rem:   result = by_zero ? a : (overflow ? '0 : sres);
            default:              result = by_zero ? a : a % b;
        endcase
        return result;
    endfunction

    function automatic muldiv_pkg::op_e pick_op(input int group);
        int k;
        case (group)
            grp_mul: k = int'(rand_bits(2) % 3);
            grp_div: k = 3 + int'(rand_bits(2));
            default: k = int'(rand_bits(3) % 7);
        endcase
        case (k)
            1:       return muldiv_pkg::op_mulh;
            2:       return muldiv_pkg::op_mulhu;
            3:       return muldiv_pkg::op_div;
            4:       return muldiv_pkg::op_divu;
            5:       return muldiv_pkg::op_rem;
            6:       return muldiv_pkg::op_remu;
            default: return muldiv_pkg::op_mul;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] actual, input logic [31:0] want);
        n_checks++;
        if (actual !== want) begin
            $display("FAILED %s: got %h, expected %h", name, actual, want);
            errors++;
        end
    endtask

    // holds the request until the scoreboard takes it.
    task automatic issue_op(input muldiv_pkg::op_e op, input int dest, input int rj, input int rk);
        logic [31:0] result;
        @(negedge clk);
        issue_valid = 1'b1;
        issue.op    = op;
        issue.dest  = 5'(dest);
        issue.rj    = 5'(rj);
        issue.rk    = 5'(rk);
        #1;
        while (!issue_ready) begin
            @(negedge clk);
            #1;
        end
        if ((rj != 0 && pending[rj]) || (rk != 0 && pending[rk])) begin
            $display("ERROR: issue to r%0d accepted while a source was still pending", dest);
            errors++;
        end
        if (dest != 0 && pending[dest]) begin
            $display("ERROR: issue to r%0d accepted while r%0d was still pending", dest, dest);
            errors++;
        end
        result         = expected_result(op, model_regs[rj], model_regs[rk]);
        expected[dest] = result;
        pending[dest]  = 1'b1;
        if (dest != 0) begin
            model_regs[dest] = result;
        end
        n_issues++;
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            issue_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (pending != '0) @(negedge clk);
        idle(4);
        check("trace count", n_traces, n_issues);
    endtask

    task automatic random_ops(input int count, input int group, input int nregs, input bit chain);
        int              dest;
        int              rj;
        int              rk;
        int              prev;
        muldiv_pkg::op_e op;
        prev = 1;
        for (int i = 0; i < count; i++) begin
            op   = pick_op(group);
            dest = 1 + int'(rand_bits(3) % nregs);
            rj   = chain ? prev : int'(rand_bits(3) % (nregs + 1));
            rk   = int'(rand_bits(3) % (nregs + 1));
            issue_op(op, dest, rj, rk);
            prev = dest;
            if (rand_bits(2) == 0) begin
                idle(int'(rand_bits(2)));
            end
        end
    endtask

    // builds -1, 2, 0x7fffffff, 0x80000000 and friends from zero registers.
    task automatic seed_regs();
        issue_op(muldiv_pkg::op_divu, 1, 0, 0);
        issue_op(muldiv_pkg::op_mulhu, 2, 1, 1);
        issue_op(muldiv_pkg::op_mul, 3, 2, 1);
        issue_op(muldiv_pkg::op_divu, 4, 1, 3);
        issue_op(muldiv_pkg::op_mul, 5, 4, 1);
        issue_op(muldiv_pkg::op_mulhu, 6, 1, 5);
        issue_op(muldiv_pkg::op_mulh, 7, 6, 4);
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && trace.we) begin
                n_traces++;
                if (!pending[trace.dest]) begin
                    $display("ERROR: trace for r%0d with no pending op", trace.dest);
                    errors++;
                end else begin
                    check($sformatf("trace.data r%0d", trace.dest), trace.data,
                          expected[trace.dest]);
                    pending[trace.dest] = 1'b0;
                end
            end
        end
    end

    initial begin
        #(n_ops * 40 * clk_period);
        $display("ERROR: watchdog timeout, ops were still outstanding");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int err0;
        lfsr        = 32'h9193;
        errors      = 0;
        n_checks    = 0;
        n_issues    = 0;
        n_traces    = 0;
        pending     = '0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            expected[i]   = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        err0 = errors;
        repeat (4) begin
            @(negedge clk);
            check("issue_ready", {31'b0, issue_ready}, 32'd1);
            check("trace.we", {31'b0, trace.we}, 32'd0);
        end
        end_test("reset", err0);

        err0 = errors;
        seed_regs();
        random_ops(n_mul, grp_mul, 7, 1'b0);
        drain();
        end_test("mul", err0);

        err0 = errors;
        seed_regs();
        issue_op(muldiv_pkg::op_div, 7, 6, 1);
        issue_op(muldiv_pkg::op_rem, 2, 6, 1);
        issue_op(muldiv_pkg::op_div, 7, 4, 0);
        issue_op(muldiv_pkg::op_rem, 2, 5, 0);
        issue_op(muldiv_pkg::op_divu, 3, 5, 0);
        issue_op(muldiv_pkg::op_remu, 4, 6, 0);
        drain();
        // r0 result is traced but never written.
        issue_op(muldiv_pkg::op_div, 0, 4, 3);
        drain();
        issue_op(muldiv_pkg::op_mul, 1, 0, 4);
        random_ops(n_div, grp_div, 7, 1'b0);
        drain();
        end_test("div", err0);

        err0 = errors;
        random_ops(n_chain, grp_any, 3, 1'b1);
        drain();
        end_test("chain", err0);

        err0 = errors;
        issue_op(muldiv_pkg::op_divu, 1, 2, 3);
        issue_op(muldiv_pkg::op_mul, 2, 4, 5);
        random_ops(n_mix, grp_any, 7, 1'b0);
        drain();
        end_test("mixed", err0);

        $display("%0d checks, %0d errors, %0d issues, %0d traces",
                 n_checks, errors, n_issues, n_traces);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- wb_arbiter.sv
module wb_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  logic            mul_valid,
    input  muldiv_pkg::wb_t mul_resp,
    output logic            mul_ready,
    input  logic            div_valid,
    input  muldiv_pkg::wb_t div_resp,
    output logic            div_ready,
    output muldiv_pkg::wb_t wr,
    output muldiv_pkg::wb_t trace
);

    logic last_div;
    logic grant_mul;
    logic grant_div;

    // on a tie the unit not served last time goes first.
    assign grant_div = div_valid && (!mul_valid || !last_div);
    assign grant_mul = mul_valid && !grant_div;

    assign mul_ready = grant_mul;
    assign div_ready = grant_div;

    always_comb begin
        if (grant_div) begin
            wr = div_resp;
        end else if (grant_mul) begin
            wr = mul_resp;
        end else begin
            wr = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_div <= 1'b0;
        end else if (grant_div) begin
            last_div <= 1'b1;
        end else if (grant_mul) begin
            last_div <= 1'b0;
        end
    end

    // trace lags the register write by one cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            trace <= '0;
        end else begin
            trace <= wr;
        end
    end

endmodule
